// File: design/bubl_pkg.sv
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Shared types for the main-CPU glue logic
////////////////////////////////////////////////////////////////////////

package bubl_pkg;

localparam int data_w = 8;
localparam int rom_aw = 18;

localparam logic [data_w-1:0] unmapped_data = 8'hff; // Open bus value

// Main CPU pins as seen by the glue logic
typedef struct packed {
    logic [15:0]       addr;
    logic [data_w-1:0] dout;
    logic              mreq_n;
    logic              iorq_n;
    logic              rd_n;
    logic              wr_n;
} cpu_bus_t;

typedef struct packed {
    logic rom;
    logic vram;
    logic pal;
    logic sound;
    logic misc;
    logic flip;    // Tokio only
    logic cabinet; // Tokio only
} main_sel_t;

typedef struct packed {
    logic [1:0]        cab_1p;
    logic [1:0]        coin;
    logic [5:0]        joystick1;
    logic [5:0]        joystick2;
    logic              service;
    logic [data_w-1:0] dipsw_a;
    logic [data_w-1:0] dipsw_b;
} cab_in_t;

typedef struct packed {
    logic [2:0] bank;
    logic       black_n;
    logic       flip;
    logic       sub_rst_n;
    logic       mcu_rst;
} main_ctrl_t;

typedef struct packed {
    logic [data_w-1:0] latch;
    logic              stb;
    logic              rst;
} snd_out_t;

endpackage

`default_nettype wire

// File: design/bubl_addr_dec.sv
`timescale 1ns/1ps
`default_nettype none

module bubl_addr_dec #(
    parameter logic [3:0] bank_offset = 4'd2
) (
    input  bubl_pkg::cpu_bus_t          bus,
    input  logic                        tokio,
    input  logic [2:0]                  bank,
    output bubl_pkg::main_sel_t         sel,
    output logic [bubl_pkg::rom_aw-1:0] main_rom_addr
);

logic       mreq;
logic       wr;
logic [7:0] page;
logic [3:0] rom_page;

assign mreq     = !bus.mreq_n;
assign wr       = !bus.wr_n;
assign page     = bus.addr[15:8];
assign rom_page = {1'b0, bank} + bank_offset; // Page of the 8000-BFFF window

////////////////////////////////////////////////////////////////////////
// Memory map
////////////////////////////////////////////////////////////////////////

always_comb begin
    // Common to both games
    sel.rom  = mreq && (!bus.addr[15] || bus.addr[15:14] == 2'b10); // 0000-BFFF
    sel.vram = mreq && bus.addr[15:13] == 3'b110;                    // C000-DFFF
    sel.pal  = mreq && bus.addr[15:9] == 7'b1111_100;                // F800-F9FF

    if (tokio) begin
        sel.sound   = mreq && page == 8'hfc && !bus.addr[7];
        sel.misc    = mreq && page == 8'hfa && bus.addr[7] && wr;
        sel.flip    = mreq && page == 8'hfb && !bus.addr[7] && wr;
        // FA00-FA7F, read side only
        sel.cabinet = mreq && bus.addr[15:7] == 9'b1111_1010_0 && bus.wr_n;
    end else begin
        sel.sound   = mreq && page == 8'hfa && !bus.addr[7];
        sel.misc    = mreq && page == 8'hfb && bus.addr[7:6] == 2'b01 && wr;
        sel.flip    = 1'b0; // Flip bit lives in the misc byte
        sel.cabinet = 1'b0; // Inputs go through the MCU here
    end
end

////////////////////////////////////////////////////////////////////////
// ROM address
////////////////////////////////////////////////////////////////////////

// Upper window is banked, lower 32kB maps straight through
assign main_rom_addr = bus.addr[15] ? {rom_page, bus.addr[13:0]}
                                    : {3'd0, bus.addr[14:0]};

endmodule

`default_nettype wire

// File: design/bubl_ctrl_reg.sv
`timescale 1ns/1ps
`default_nettype none

module bubl_ctrl_reg (
    input  logic                 clk24,
    input  logic                 rst,
    input  bubl_pkg::cpu_bus_t   bus,
    input  bubl_pkg::main_sel_t  sel,
    input  logic                 tokio,
    output bubl_pkg::main_ctrl_t ctrl
);

logic flip_we;

// Tokio has a separate flip register, bubble keeps it in the misc byte
assign flip_we = tokio ? sel.flip : sel.misc;

always_ff @(posedge clk24 or posedge rst) begin
    if (rst) begin
        ctrl.bank      <= 3'd0;
        ctrl.black_n   <= 1'b0; // Screen blanked
        ctrl.flip      <= 1'b0;
        ctrl.sub_rst_n <= 1'b0; // Sub CPU held
        ctrl.mcu_rst   <= 1'b1; // MCU held
    end else begin
        if (sel.misc) begin
            // Bank bit 2 is inverted on the bubble board
            ctrl.bank    <= tokio ? bus.dout[2:0] : bus.dout[2:0] ^ 3'b100;
            ctrl.black_n <= bus.dout[6];
            if (tokio) begin
                ctrl.sub_rst_n <= 1'b1;
                ctrl.mcu_rst   <= 1'b1;
            end else begin
                ctrl.sub_rst_n <= bus.dout[4];
                ctrl.mcu_rst   <= ~bus.dout[5]; // Active high
            end
        end
        if (flip_we) begin
            ctrl.flip <= bus.dout[7];
        end
    end
end

endmodule

`default_nettype wire

// File: design/bubl_snd_comm.sv
`timescale 1ns/1ps
`default_nettype none

module bubl_snd_comm (
    input  logic                clk24,
    input  logic                rst,
    input  bubl_pkg::cpu_bus_t  bus,
    input  bubl_pkg::main_sel_t sel,
    input  logic                main_stb,
    output bubl_pkg::snd_out_t  snd,
    output logic                main_flag
);

logic wr;
logic last_stb;
logic stb_edge;

assign wr       = sel.sound && !bus.wr_n;
assign stb_edge = main_stb && !last_stb;

////////////////////////////////////////////////////////////////////////
// Main to sound
////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk24 or posedge rst) begin
    if (rst) begin
        snd.latch <= '0;
        snd.stb   <= 1'b0;
        snd.rst   <= 1'b0;
    end else begin
        snd.stb <= wr && bus.addr[1:0] == 2'b00; // Follows the write
        if (wr) begin
            case (bus.addr[1:0])
                2'b00: snd.latch <= bus.dout;
                2'b11: snd.rst   <= bus.dout[0];
                default: ;
            endcase
        end
    end
end

////////////////////////////////////////////////////////////////////////
// Sound to main flag
////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk24 or posedge rst) begin
    if (rst) begin
        last_stb  <= 1'b0;
        main_flag <= 1'b0;
    end else begin
        last_stb <= main_stb;
        if (sel.sound && !bus.rd_n) begin
            main_flag <= 1'b0; // Read wins over a new strobe
        end else if (stb_edge) begin
            main_flag <= 1'b1;
        end
    end
end

endmodule

`default_nettype wire

// File: design/bubl_rd_mux.sv
`timescale 1ns/1ps
`default_nettype none

module bubl_rd_mux (
    input  logic                          clk24,
    input  logic                          rst,
    input  bubl_pkg::cpu_bus_t            bus,
    input  bubl_pkg::main_sel_t           sel,
    input  bubl_pkg::cab_in_t             cab,
    input  logic [bubl_pkg::data_w-1:0]   vram_dout,
    input  logic [bubl_pkg::data_w-1:0]   pal_dout,
    input  logic [bubl_pkg::data_w-1:0]   main_rom_data,
    input  logic [bubl_pkg::data_w-1:0]   main_latch,
    input  logic                          main_flag,
    input  logic                          snd_flag,
    output logic [bubl_pkg::data_w-1:0]   main_din
);

logic [bubl_pkg::data_w-1:0] cab_dout;
logic [bubl_pkg::data_w-1:0] snd_dout;

// Status byte or command from the sound CPU
assign snd_dout = bus.addr[0] ? {6'h3f, main_flag, snd_flag} : main_latch;

////////////////////////////////////////////////////////////////////////
// Tokio cabinet inputs
////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk24) begin
    case (bus.addr[2:0])
        3'd3:    cab_dout <= cab.dipsw_a;
        3'd4:    cab_dout <= cab.dipsw_b;
        3'd5:    cab_dout <= {4'hf, cab.coin, cab.service, 1'b1};
        3'd6:    cab_dout <= {1'b1, cab.cab_1p[0], cab.joystick1};
        3'd7:    cab_dout <= {1'b1, cab.cab_1p[1], cab.joystick2};
        default: cab_dout <= bubl_pkg::unmapped_data;
    endcase
end

////////////////////////////////////////////////////////////////////////
// CPU read data
////////////////////////////////////////////////////////////////////////

always_ff @(posedge clk24 or posedge rst) begin
    if (rst) begin
        main_din <= bubl_pkg::unmapped_data;
    end else begin
        if (sel.rom)
            main_din <= main_rom_data;
        else if (sel.vram)
            main_din <= vram_dout;
        else if (sel.pal)
            main_din <= pal_dout;
        else if (sel.sound)
            main_din <= snd_dout;
        else if (sel.cabinet)
            main_din <= cab_dout; // Needs the address one cycle earlier
        else
            main_din <= bubl_pkg::unmapped_data; // Work RAM, comm RAM and I/O too
    end
end

endmodule

`default_nettype wire

// File: design/bubl_main_top.sv
`timescale 1ns/1ps
`default_nettype none

module bubl_main_top #(
    parameter logic [3:0] bank_offset = 4'd2
) (
    input  logic                          clk24,
    input  logic                          rst,
    input  logic                          tokio,   // Game select

    // Main CPU pins
    input  bubl_pkg::cpu_bus_t            bus,
    output logic [bubl_pkg::data_w-1:0]   main_din,

    // Cabinet
    input  bubl_pkg::cab_in_t             cab,

    // Video
    input  logic [bubl_pkg::data_w-1:0]   vram_dout,
    input  logic [bubl_pkg::data_w-1:0]   pal_dout,
    output logic [12:0]                   cpu_addr,
    output logic [bubl_pkg::data_w-1:0]   cpu_dout,
    output logic                          cpu_rnw,

    // ROM
    input  logic [bubl_pkg::data_w-1:0]   main_rom_data,
    output logic [bubl_pkg::rom_aw-1:0]   main_rom_addr,

    // Sound CPU
    input  logic [bubl_pkg::data_w-1:0]   main_latch,
    input  logic                          snd_flag,
    input  logic                          main_stb,
    output bubl_pkg::snd_out_t            snd,
    output logic                          main_flag,

    output bubl_pkg::main_sel_t           sel,
    output bubl_pkg::main_ctrl_t          ctrl
);

// Video side sees the low address, data and direction
assign cpu_addr = bus.addr[12:0];
assign cpu_dout = bus.dout;
assign cpu_rnw  = bus.wr_n;

bubl_addr_dec #(.bank_offset(bank_offset)) u_addr_dec (
    .bus           ( bus           ),
    .tokio         ( tokio         ),
    .bank          ( ctrl.bank     ),
    .sel           ( sel           ),
    .main_rom_addr ( main_rom_addr )
);

bubl_ctrl_reg u_ctrl_reg (
    .clk24 ( clk24 ),
    .rst   ( rst   ),
    .bus   ( bus   ),
    .sel   ( sel   ),
    .tokio ( tokio ),
    .ctrl  ( ctrl  )
);

bubl_snd_comm u_snd_comm (
    .clk24     ( clk24     ),
    .rst       ( rst       ),
    .bus       ( bus       ),
    .sel       ( sel       ),
    .main_stb  ( main_stb  ),
    .snd       ( snd       ),
    .main_flag ( main_flag )
);

bubl_rd_mux u_rd_mux (
    .clk24         ( clk24         ),
    .rst           ( rst           ),
    .bus           ( bus           ),
    .sel           ( sel           ),
    .cab           ( cab           ),
    .vram_dout     ( vram_dout     ),
    .pal_dout      ( pal_dout      ),
    .main_rom_data ( main_rom_data ),
    .main_latch    ( main_latch    ),
    .main_flag     ( main_flag     ),
    .snd_flag      ( snd_flag      ),
    .main_din      ( main_din      )
);

endmodule

`default_nettype wire

// File: dv/bubl_clkgen.sv
`timescale 1ns/1ps
`default_nettype none

module bubl_clkgen #(
    parameter real period     = 4.0,
    parameter int  rst_cycles = 10
) (
    output logic clk24,
    output logic rst
);

initial begin
    clk24 = 1'b0;
    forever #(period / 2.0) clk24 = ~clk24;
end

// Release lands on a falling edge, clear of the sampling edge
initial begin
    rst = 1'b1;
    repeat (rst_cycles) @(posedge clk24);
    @(negedge clk24);
    rst = 1'b0;
end

endmodule

`default_nettype wire

// File: dv/bubl_bus_sva.sv
`timescale 1ns/1ps
`default_nettype none

module bubl_bus_sva (
    input logic                clk24,
    input logic                rst,
    input logic                tokio,
    input bubl_pkg::cpu_bus_t  bus,
    input bubl_pkg::main_sel_t sel,
    input bubl_pkg::snd_out_t  snd
);

logic [6:0] sel_bits;

assign sel_bits = sel;

// Decoded regions never overlap
one_select: assert property (@(posedge clk24) disable iff (rst) $onehot0(sel_bits))
    else $error("more than one chip select active");

// Strobe is the registered copy of a sound write
stb_needs_sound: assert property (@(posedge clk24) disable iff (rst)
    snd.stb |-> $past(sel.sound && !bus.wr_n))
    else $error("sound strobe high without a sound write");

bubble_no_tokio_sel: assert property (@(posedge clk24) disable iff (rst)
    !tokio |-> !sel.flip && !sel.cabinet)
    else $error("flip or cabinet select active in bubble");

endmodule

bind bubl_main_top bubl_bus_sva u_bus_sva (
    .clk24 ( clk24 ),
    .rst   ( rst   ),
    .tokio ( tokio ),
    .bus   ( bus   ),
    .sel   ( sel   ),
    .snd   ( snd   )
);

`default_nettype wire

// File: dv/bubl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bubl_tb;

localparam logic [3:0] bank_offset = 4'd2;
localparam logic [1:0] acc_idle = 2'd0;
localparam logic [1:0] acc_rd   = 2'd1;
localparam logic [1:0] acc_wr   = 2'd2;
localparam logic [1:0] acc_io   = 2'd3; // I/O read

typedef struct packed {
    bubl_pkg::cpu_bus_t bus;
    logic               tokio;
    bubl_pkg::cab_in_t  cab;
    logic [7:0]         vram;
    logic [7:0]         pal;
    logic [7:0]         rom;
    logic [7:0]         latch;
    logic               snd_flag;
    logic               main_stb;
} stim_t;

typedef struct packed {
    bubl_pkg::main_sel_t         sel;
    logic [bubl_pkg::rom_aw-1:0] rom_addr;
    bubl_pkg::main_ctrl_t        ctrl;
    bubl_pkg::snd_out_t          snd;
    logic                        flag;
    logic                        last_stb;
    logic [7:0]                  cab_q;
    logic [7:0]                  din;
    logic [12:0]                 cpu_addr;
    logic [7:0]                  cpu_dout;
    logic                        cpu_rnw;
} model_t;

logic                        clk24;
logic                        rst;
stim_t                       drv;
model_t                      mdl;
logic [7:0]                  main_din;
logic [bubl_pkg::rom_aw-1:0] main_rom_addr;
bubl_pkg::main_sel_t         sel;
bubl_pkg::main_ctrl_t        ctrl;
bubl_pkg::snd_out_t          snd;
logic                        main_flag;
logic [12:0]                 cpu_addr;
logic [7:0]                  cpu_dout;
logic                        cpu_rnw;
integer                      seed = 32'h999ffd9f;
integer                      err_count = 0;
string                       test_name = "init";

bubl_clkgen #(.period(4.0), .rst_cycles(10)) u_clkgen (.clk24(clk24), .rst(rst));

bubl_main_top #(.bank_offset(bank_offset)) u_dut (
    .clk24 ( clk24 ), .rst ( rst ), .tokio ( drv.tokio ),
    .bus ( drv.bus ), .main_din ( main_din ), .cab ( drv.cab ),
    .vram_dout ( drv.vram ), .pal_dout ( drv.pal ),
    .cpu_addr ( cpu_addr ), .cpu_dout ( cpu_dout ), .cpu_rnw ( cpu_rnw ),
    .main_rom_data ( drv.rom ), .main_rom_addr ( main_rom_addr ),
    .main_latch ( drv.latch ), .snd_flag ( drv.snd_flag ), .main_stb ( drv.main_stb ),
    .snd ( snd ), .main_flag ( main_flag ), .sel ( sel ), .ctrl ( ctrl )
);

////////////////////////////////////////////////////////////////////////
// Reference model, one clock per call
////////////////////////////////////////////////////////////////////////

function automatic model_t ref_model(model_t st, stim_t in, logic in_rst);
    model_t              nx;
    bubl_pkg::main_sel_t s;
    logic [7:0]          page;
    logic [7:0]          d;
    logic                wr;
    logic [3:0]          rom_page;
    nx   = st;
    s    = '0;
    page = in.bus.addr[15:8];
    d    = in.bus.dout;
    wr   = !in.bus.wr_n;
    if (!in.bus.mreq_n) begin
        s.rom  = !in.bus.addr[15] || in.bus.addr[15:14] == 2'b10;
        s.vram = in.bus.addr[15:13] == 3'b110;
        s.pal  = page[7:1] == 7'h7c; // F800-F9FF
        if (in.tokio) begin
            s.sound   = page == 8'hfc && !in.bus.addr[7];
            s.misc    = page == 8'hfa && in.bus.addr[7] && wr;
            s.flip    = page == 8'hfb && !in.bus.addr[7] && wr;
            s.cabinet = page == 8'hfa && !in.bus.addr[7] && !wr;
        end else begin
            s.sound = page == 8'hfa && !in.bus.addr[7];
            s.misc  = page == 8'hfb && in.bus.addr[7:6] == 2'b01 && wr;
        end
    end
    nx.sel = s;
    // Video side pass-through
    nx.cpu_addr = in.bus.addr[12:0];
    nx.cpu_dout = d;
    nx.cpu_rnw  = !wr;
    if (in_rst) begin
        nx.ctrl     = '{bank: 3'd0, black_n: 1'b0, flip: 1'b0, sub_rst_n: 1'b0, mcu_rst: 1'b1};
        nx.snd      = '0;
        nx.flag     = 1'b0;
        nx.last_stb = 1'b0;
        nx.din      = 8'hff;
    end else begin
        if (s.misc) begin
            nx.ctrl.bank      = in.tokio ? d[2:0] : {~d[2], d[1:0]};
            nx.ctrl.black_n   = d[6];
            nx.ctrl.sub_rst_n = in.tokio || d[4];
            nx.ctrl.mcu_rst   = in.tokio || !d[5];
        end
        if (in.tokio ? s.flip : s.misc)
            nx.ctrl.flip = d[7];
        nx.snd.stb = s.sound && wr && in.bus.addr[1:0] == 2'd0;
        if (nx.snd.stb)
            nx.snd.latch = d;
        if (s.sound && wr && in.bus.addr[1:0] == 2'd3)
            nx.snd.rst = d[0];
        if (s.sound && !in.bus.rd_n)
            nx.flag = 1'b0;
        else if (in.main_stb && !st.last_stb)
            nx.flag = 1'b1;
        nx.last_stb = in.main_stb;
        if (s.rom)          nx.din = in.rom;
        else if (s.vram)    nx.din = in.vram;
        else if (s.pal)     nx.din = in.pal;
        else if (s.sound)   nx.din = in.bus.addr[0] ? {6'h3f, st.flag, in.snd_flag} : in.latch;
        else if (s.cabinet) nx.din = st.cab_q;
        else                nx.din = bubl_pkg::unmapped_data;
    end
    case (in.bus.addr[2:0]) // Cabinet word, not reset
        3'd3:    nx.cab_q = in.cab.dipsw_a;
        3'd4:    nx.cab_q = in.cab.dipsw_b;
        3'd5:    nx.cab_q = {4'hf, in.cab.coin, in.cab.service, 1'b1};
        3'd6:    nx.cab_q = {1'b1, in.cab.cab_1p[0], in.cab.joystick1};
        3'd7:    nx.cab_q = {1'b1, in.cab.cab_1p[1], in.cab.joystick2};
        default: nx.cab_q = 8'hff;
    endcase
    rom_page    = {1'b0, nx.ctrl.bank} + bank_offset;
    nx.rom_addr = in.bus.addr[15] ? {rom_page, in.bus.addr[13:0]} : {3'd0, in.bus.addr[14:0]};
    return nx;
endfunction

task automatic stop_run(input string why);
    err_count++;
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopped at first error");
endtask

task automatic check_sel(input string what, input bubl_pkg::main_sel_t exp,
                         input bubl_pkg::main_sel_t act);
    if (act !== exp)
        stop_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
endtask

task automatic check_ctrl(input string what, input bubl_pkg::main_ctrl_t exp,
                          input bubl_pkg::main_ctrl_t act);
    if (act !== exp)
        stop_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
endtask

task automatic check_snd(input string what, input bubl_pkg::snd_out_t exp,
                         input bubl_pkg::snd_out_t act);
    if (act !== exp)
        stop_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
endtask

task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
        stop_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
endtask

task automatic check_rom_addr(input string what, input logic [bubl_pkg::rom_aw-1:0] exp,
                              input logic [bubl_pkg::rom_aw-1:0] act);
    if (act !== exp)
        stop_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
endtask

task automatic check_cpu_addr(input string what, input logic [12:0] exp,
                              input logic [12:0] act);
    if (act !== exp)
        stop_run($sformatf("ERR %s %s expected %h actual %h", test_name, what, exp, act));
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp)
        stop_run($sformatf("ERR %s %s expected %b actual %b", test_name, what, exp, act));
endtask

// Outputs settle 1 ns after the edge, inputs still held
always @(posedge clk24) begin
    #1;
    mdl = ref_model(mdl, drv, rst);
    if (!rst) begin
        check_sel("sel", mdl.sel, sel);
        check_rom_addr("rom_addr", mdl.rom_addr, main_rom_addr);
        check_ctrl("ctrl", mdl.ctrl, ctrl);
        check_snd("snd", mdl.snd, snd);
        check_byte("main_din", mdl.din, main_din);
        check_bit("main_flag", mdl.flag, main_flag);
        check_cpu_addr("cpu_addr", mdl.cpu_addr, cpu_addr);
        check_byte("cpu_dout", mdl.cpu_dout, cpu_dout);
        check_bit("cpu_rnw", mdl.cpu_rnw, cpu_rnw);
    end
end

////////////////////////////////////////////////////////////////////////
// Stimulus, all on the falling edge
////////////////////////////////////////////////////////////////////////

task automatic drive(input logic [15:0] addr, input logic [7:0] data, input logic [1:0] kind);
    @(negedge clk24);
    drv.bus.addr   = addr;
    drv.bus.dout   = data;
    drv.bus.mreq_n = !(kind == acc_rd || kind == acc_wr);
    drv.bus.iorq_n = kind != acc_io;
    drv.bus.rd_n   = !(kind == acc_rd || kind == acc_io);
    drv.bus.wr_n   = kind != acc_wr;
endtask

task automatic shuffle_inputs();
    drv.vram     = 8'($random(seed));
    drv.pal      = 8'($random(seed));
    drv.rom      = 8'($random(seed));
    drv.latch    = 8'($random(seed));
    drv.snd_flag = 1'($random(seed));
    drv.cab      = 33'({$random(seed), $random(seed)});
endtask

initial begin
    integer     n;
    integer     i;
    integer     r;
    logic [7:0] exp;
    mdl            = '0;
    drv            = '0;
    drv.bus.mreq_n = 1'b1;
    drv.bus.iorq_n = 1'b1;
    drv.bus.rd_n   = 1'b1;
    drv.bus.wr_n   = 1'b1;

    test_name = "reset";
    n = 0;
    while (rst !== 1'b0 && n < 50) begin
        @(negedge clk24);
        n++;
    end
    if (rst !== 1'b0)
        stop_run("reset was never released");
    drive(16'h0000, 8'h00, acc_idle);
    check_ctrl("ctrl", '{3'd0, 1'b0, 1'b0, 1'b0, 1'b1}, ctrl);
    check_snd("snd", '0, snd);
    check_bit("main_flag", 1'b0, main_flag);

    test_name = "decode"; // Both games, bank moved by misc writes
    for (i = 0; i < 8; i++) begin
        drv.tokio = i[2];
        drive(i[2] ? 16'hfa80 : 16'hfb40, 8'($random(seed)), acc_wr);
        repeat (60) begin
            r = $random(seed);
            drive(r[15:0], r[23:16], r[25:24]);
            shuffle_inputs();
        end
    end

    test_name = "read";
    drv.tokio = 1'b0;
    drive(16'h1234, 8'h00, acc_rd);
    drive(16'h9abc, 8'h00, acc_rd);
    drive(16'hc100, 8'h00, acc_rd);
    drive(16'hf850, 8'h00, acc_rd);
    drive(16'h0010, 8'h00, acc_io);
    drive(16'he000, 8'h00, acc_rd);
    drive(16'h0000, 8'h00, acc_idle);
    check_byte("unmapped", 8'hff, main_din);

    test_name = "ctrl";
    drive(16'hfb40, 8'h55, acc_wr);
    drive(16'h0000, 8'h00, acc_idle);
    check_ctrl("bubble 55", '{3'd1, 1'b1, 1'b0, 1'b1, 1'b1}, ctrl);
    drive(16'hfb40, 8'ha3, acc_wr);
    drive(16'h0000, 8'h00, acc_idle);
    check_ctrl("bubble a3", '{3'd7, 1'b0, 1'b1, 1'b0, 1'b0}, ctrl);
    drv.tokio = 1'b1;
    // Flip write clears flip, then a misc write with bit 7 set must leave it
    drive(16'hfb00, 8'h00, acc_wr);
    drive(16'hfa80, 8'hc2, acc_wr);
    drive(16'h0000, 8'h00, acc_idle);
    check_ctrl("tokio", '{3'd2, 1'b1, 1'b0, 1'b1, 1'b1}, ctrl);

    test_name = "sound";
    drive(16'hfc00, 8'h5a, acc_wr);
    n = 0;
    while (snd.stb !== 1'b1 && n < 8) begin
        drive(16'h0000, 8'h00, acc_idle);
        n++;
    end
    if (snd.stb !== 1'b1)
        stop_run("sound strobe never came after a latch write");
    check_byte("latch", 8'h5a, snd.latch);
    drive(16'hfc03, 8'h01, acc_wr);
    drv.main_stb = 1'b1;
    n = 0;
    while (main_flag !== 1'b1 && n < 8) begin
        drive(16'h0000, 8'h00, acc_idle);
        n++;
    end
    if (main_flag !== 1'b1)
        stop_run("main_flag did not rise after a main_stb edge");
    drive(16'hfc01, 8'h00, acc_rd);
    drive(16'h0000, 8'h00, acc_idle);
    check_byte("status", {6'h3f, 1'b1, drv.snd_flag}, main_din);
    check_bit("flag cleared", 1'b0, main_flag);
    drv.main_stb = 1'b0;

    test_name = "cabinet";
    shuffle_inputs();
    for (i = 3; i < 8; i++) begin
        drive(16'hfa00 | i[15:0], 8'h00, acc_rd);
        drive(16'hfa00 | i[15:0], 8'h00, acc_rd); // Held for the registered word
        drive(16'h0000, 8'h00, acc_idle);
        case (i)
            3:       exp = drv.cab.dipsw_a;
            4:       exp = drv.cab.dipsw_b;
            5:       exp = {4'hf, drv.cab.coin, drv.cab.service, 1'b1};
            6:       exp = {1'b1, drv.cab.cab_1p[0], drv.cab.joystick1};
            default: exp = {1'b1, drv.cab.cab_1p[1], drv.cab.joystick2};
        endcase
        check_byte($sformatf("offset %0d", i), exp, main_din);
    end

    drive(16'h0000, 8'h00, acc_idle);
    if (err_count == 0) begin
        $display("Simulation completed successfully");
        $finish;
    end else begin
        $display("Simulation failed");
        $fatal(1, "errors were counted");
    end
end

endmodule

`default_nettype wire

// File: compile.f
design/bubl_pkg.sv
design/bubl_addr_dec.sv
design/bubl_ctrl_reg.sv
design/bubl_snd_comm.sv
design/bubl_rd_mux.sv
design/bubl_main_top.sv
dv/bubl_clkgen.sv
dv/bubl_bus_sva.sv
dv/bubl_tb.sv

// File: Bender.yml
package:
  name: bubl_main

sources:
  - design/bubl_pkg.sv
  - design/bubl_addr_dec.sv
  - design/bubl_ctrl_reg.sv
  - design/bubl_snd_comm.sv
  - design/bubl_rd_mux.sv
  - design/bubl_main_top.sv
  - target: test
    files:
      - dv/bubl_clkgen.sv
      - dv/bubl_bus_sva.sv
      - dv/bubl_tb.sv
